/* ingress_part_ram.sv */
/* Write takes effect at the clock edge; read is combinational from rd_addr.
   Addresses above depth-1 are never produced by the schedulers. */

`timescale 1ns/1ps

module ingress_part_ram #(
    parameter int  depth     = 64,
    parameter type payload_t = logic [7:0]
) (
    input  logic                          ing_bus,
    input  logic                          wr_en,
    input  router_ingress_pkg::buf_addr_t wr_addr,
    input  payload_t                      wr_data,
    input  router_ingress_pkg::buf_addr_t rd_addr,
    output payload_t                      rd_data
);

    // Storage style is left to synthesis
    payload_t mem [depth];

    always_ff @(posedge ing_bus) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Same-cycle read, a write on this edge shows up next cycle
    assign rd_data = mem[rd_addr];

endmodule

/* ingress_read_sched.sv */
/* No back-pressure on the output; a packet streams out on consecutive cycles once started.
   Output lags the issue decision by two cycles. */

`timescale 1ns/1ps

module ingress_read_sched #(
    parameter int num_ports = router_ingress_pkg::max_ports
) (
    input  logic                           ing_bus,
    input  logic                           rst_n,
    input  router_ingress_pkg::part_ptr_t  attr_wr_ptr [num_ports],
    output router_ingress_pkg::buf_addr_t  attr_rd_addr,
    input  router_ingress_pkg::pkt_attr_t  attr_rd_data,
    output router_ingress_pkg::buf_addr_t  word_rd_addr,
    input  router_ingress_pkg::word_data_t word_rd_data,
    output router_ingress_pkg::part_ptr_t  word_rd_ptr [num_ports],
    output logic                           out_valid,
    output router_ingress_pkg::ing_out_t   out_word
);

    import router_ingress_pkg::*;

    localparam port_id_t last_port = port_id_t'(num_ports - 1);

    port_id_t  rd_sel;
    port_id_t  nxt_sel;
    part_ptr_t attr_rd_ptr [num_ports];
    logic      pkt_ready;
    logic      issue_last;

    // Stage 0 holds the issued read address
    logic     s0_valid;
    logic     s0_last;
    len_t     s0_len;
    port_id_t s0_port;
    keep_t    last_keep;

    // Stage 1 drives the output
    logic       s1_valid;
    logic       s1_last;
    len_t       s1_len;
    port_id_t   s1_port;
    word_data_t s1_data;
    keep_t      s1_keep;

    ////////////////////
    // Poll and issue

    assign nxt_sel      = (rd_sel == last_port) ? '0 : rd_sel + 1'b1;
    assign attr_rd_addr = {rd_sel, attr_rd_ptr[rd_sel]};

    // Empty test lives here only
    assign pkt_ready  = (attr_rd_ptr[rd_sel] != attr_wr_ptr[rd_sel]);
    assign issue_last = (word_rd_ptr[rd_sel] == attr_rd_data.last_ptr);

    always_ff @(posedge ing_bus) begin
        if (!rst_n) begin
            rd_sel      <= '0;
            attr_rd_ptr <= '{default: '0};
            word_rd_ptr <= '{default: '0};
            s0_valid    <= 1'b0;
            s0_last     <= 1'b0;
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
        end else begin
            s0_valid <= pkt_ready;
            s0_last  <= pkt_ready && issue_last;
            s1_valid <= s0_valid;
            s1_last  <= s0_last;

            if (pkt_ready) begin
                word_rd_ptr[rd_sel] <= word_rd_ptr[rd_sel] + 1'b1;
                // Stay on this port until the whole packet is issued
                if (issue_last) begin
                    attr_rd_ptr[rd_sel] <= attr_rd_ptr[rd_sel] + 1'b1;
                    rd_sel              <= nxt_sel;
                end
            end else begin
                rd_sel <= nxt_sel;
            end
        end
    end

    ////////////////////
    // Keep for the last word

    always_comb begin
        last_keep = '0;
        for (int i = 0; i < bus_bytes; i++) begin
            if (i < s0_len[bus_byte_w-1:0]) begin
                last_keep[i] = 1'b1;
            end
        end
        // Length a multiple of the word size
        if (s0_len[bus_byte_w-1:0] == '0) begin
            last_keep = '1;
        end
    end

    ////////////////////
    // Data pipeline

    always_ff @(posedge ing_bus) begin
        word_rd_addr <= {rd_sel, word_rd_ptr[rd_sel]};
        s0_len       <= attr_rd_data.byte_len;
        s0_port      <= rd_sel;

        s1_len  <= s0_len;
        s1_port <= s0_port;
        s1_data <= word_rd_data;
        s1_keep <= s0_last ? last_keep : '1;
    end

    assign out_valid             = s1_valid;
    assign out_word.data         = s1_data;
    assign out_word.keep         = s1_keep;
    assign out_word.last         = s1_last;
    assign out_word.meta.port_id = s1_port;
    assign out_word.meta.byte_len = s1_len;

endmodule

/* ingress_write_sched.sv */
/* One port is ready per cycle in fixed rotation, so each port gets 1/num_ports of the bus.
   A packet that does not fit its partition is dropped whole and flagged on overflow. */

`timescale 1ns/1ps

module ingress_write_sched #(
    parameter int num_ports = router_ingress_pkg::max_ports
) (
    input  logic                             ing_bus,
    input  logic                             rst_n,
    input  router_ingress_pkg::stream_word_t in_word [num_ports],
    input  logic [num_ports-1:0]             in_valid,
    output logic [num_ports-1:0]             in_ready,
    input  router_ingress_pkg::part_ptr_t    word_rd_ptr [num_ports],
    output logic                             word_wr_en,
    output router_ingress_pkg::buf_addr_t    word_wr_addr,
    output router_ingress_pkg::word_data_t   word_wr_data,
    output logic                             attr_wr_en,
    output router_ingress_pkg::buf_addr_t    attr_wr_addr,
    output router_ingress_pkg::pkt_attr_t    attr_wr_data,
    output router_ingress_pkg::part_ptr_t    attr_wr_ptr [num_ports],
    output logic [num_ports-1:0]             overflow
);

    import router_ingress_pkg::*;

    typedef logic [len_w-bus_byte_w-1:0] wcnt_t;

    localparam port_id_t last_port = port_id_t'(num_ports - 1);

    // Per-port state
    port_id_t             wr_sel;
    part_ptr_t            wr_ptr [num_ports];
    part_ptr_t            commit_ptr [num_ports];
    wcnt_t                wcnt [num_ports];
    logic [num_ports-1:0] drop;

    // Selected port this cycle
    stream_word_t        cur_word;
    logic                accept;
    part_ptr_t           cur_ptr;
    part_ptr_t           nxt_ptr;
    logic                full;
    logic [bus_byte_w:0] keep_cnt;
    pkt_attr_t           attr_enc;

    // Attribute pipeline
    logic      attr_pend_en;
    pkt_attr_t attr_pend;
    port_id_t  attr_pend_port;
    port_id_t  attr_wr_port;

    ////////////////////
    // Slot selection

    always_comb begin
        in_ready         = '0;
        in_ready[wr_sel] = 1'b1;
    end

    assign cur_word = in_word[wr_sel];
    assign accept   = in_valid[wr_sel];
    assign cur_ptr  = wr_ptr[wr_sel];
    assign nxt_ptr  = cur_ptr + 1'b1;

    // Leave one slot free so the word the reader is fetching is never overwritten
    assign full = (nxt_ptr == word_rd_ptr[wr_sel]);

    always_comb begin
        keep_cnt = '0;
        for (int i = 0; i < bus_bytes; i++) begin
            keep_cnt = keep_cnt + cur_word.keep[i];
        end
    end

    // Full words so far plus the bytes of the current word
    assign attr_enc.last_ptr = cur_ptr;
    assign attr_enc.byte_len = {wcnt[wr_sel], {bus_byte_w{1'b0}}} + len_t'(keep_cnt);

    ////////////////////
    // Pointers and drop

    always_ff @(posedge ing_bus) begin
        if (!rst_n) begin
            wr_sel       <= '0;
            wr_ptr       <= '{default: '0};
            commit_ptr   <= '{default: '0};
            wcnt         <= '{default: '0};
            drop         <= '0;
            attr_wr_ptr  <= '{default: '0};
            overflow     <= '0;
            word_wr_en   <= 1'b0;
            attr_pend_en <= 1'b0;
            attr_wr_en   <= 1'b0;
        end else begin
            wr_sel       <= (wr_sel == last_port) ? '0 : wr_sel + 1'b1;
            overflow     <= '0;
            word_wr_en   <= 1'b0;
            attr_pend_en <= 1'b0;
            attr_wr_en   <= attr_pend_en;

            if (accept) begin
                if (full || drop[wr_sel]) begin
                    // Discard until the last word, then rewind to the committed point
                    drop[wr_sel]   <= ~cur_word.last;
                    wr_ptr[wr_sel] <= commit_ptr[wr_sel];
                    if (cur_word.last) begin
                        overflow[wr_sel] <= 1'b1;
                    end
                end else begin
                    word_wr_en     <= 1'b1;
                    wr_ptr[wr_sel] <= nxt_ptr;
                    if (cur_word.last) begin
                        attr_pend_en       <= 1'b1;
                        commit_ptr[wr_sel] <= nxt_ptr;
                    end
                end

                if (cur_word.last) begin
                    wcnt[wr_sel] <= '0;
                end else begin
                    wcnt[wr_sel] <= wcnt[wr_sel] + 1'b1;
                end
            end

            // Packet becomes visible to the reader on the attribute write edge
            if (attr_wr_en) begin
                attr_wr_ptr[attr_wr_port] <= attr_wr_ptr[attr_wr_port] + 1'b1;
            end
        end
    end

    ////////////////////
    // Memory write data

    always_ff @(posedge ing_bus) begin
        word_wr_addr   <= {wr_sel, cur_ptr};
        word_wr_data   <= cur_word.data;
        attr_pend      <= attr_enc;
        attr_pend_port <= wr_sel;
        attr_wr_data   <= attr_pend;
        attr_wr_port   <= attr_pend_port;
    end

    // Live pointer, so back-to-back commits on one port land in separate entries
    assign attr_wr_addr = {attr_wr_port, attr_wr_ptr[attr_wr_port]};

endmodule

/* project.f */
router_ingress_pkg.sv
ingress_part_ram.sv
ingress_write_sched.sv
ingress_read_sched.sv
router_ingress_top.sv
tb_router_ingress.sv

/* router_ingress_pkg.sv */
/* Word width and partition depth are fixed here and shared by RTL and testbench.
   A partition keeps one slot free, so at most part_depth-1 words wait per port. */

package router_ingress_pkg;

    ////////////////////
    // Sizes

    localparam int bus_bytes  = 8;
    localparam int bus_byte_w = $clog2(bus_bytes);
    localparam int part_depth = 64;
    localparam int part_ptr_w = $clog2(part_depth);
    localparam int max_ports  = 4;
    localparam int port_id_w  = $clog2(max_ports);
    // 11 bits cover a 1500 byte MTU
    localparam int len_w      = 11;
    // Buffer address is {port, partition pointer}
    localparam int buf_addr_w = port_id_w + part_ptr_w;

    ////////////////////
    // Scalar types

    typedef logic [bus_bytes*8-1:0] word_data_t;
    typedef logic [bus_bytes-1:0]   keep_t;
    typedef logic [part_ptr_w-1:0]  part_ptr_t;
    typedef logic [port_id_w-1:0]   port_id_t;
    typedef logic [len_w-1:0]       len_t;
    typedef logic [buf_addr_w-1:0]  buf_addr_t;

    ////////////////////
    // Records

    typedef struct packed {
        word_data_t data;
        keep_t      keep;
        logic       last;
    } stream_word_t;

    // One entry per committed packet
    typedef struct packed {
        part_ptr_t last_ptr;
        len_t      byte_len;
    } pkt_attr_t;

    typedef struct packed {
        port_id_t port_id;
        len_t     byte_len;
    } ing_meta_t;

    typedef struct packed {
        word_data_t data;
        keep_t      keep;
        logic       last;
        ing_meta_t  meta;
    } ing_out_t;

endpackage

/* router_ingress_top.sv */
/* Ports beyond num_ports-1 do not exist; num_ports must be 1 to max_ports.
   Output has no ready, so the consumer must always accept. */

`timescale 1ns/1ps

module router_ingress_top #(
    parameter int num_ports = router_ingress_pkg::max_ports
) (
    input  logic                             ing_bus,
    input  logic                             rst_n,
    input  router_ingress_pkg::stream_word_t in_word [num_ports],
    input  logic [num_ports-1:0]             in_valid,
    output logic [num_ports-1:0]             in_ready,
    output logic                             out_valid,
    output router_ingress_pkg::ing_out_t     out_word,
    output logic [num_ports-1:0]             overflow
);

    import router_ingress_pkg::*;

    // Word memory
    logic       word_wr_en;
    buf_addr_t  word_wr_addr;
    word_data_t word_wr_data;
    buf_addr_t  word_rd_addr;
    word_data_t word_rd_data;

    // Attribute memory
    logic      attr_wr_en;
    buf_addr_t attr_wr_addr;
    pkt_attr_t attr_wr_data;
    buf_addr_t attr_rd_addr;
    pkt_attr_t attr_rd_data;

    // Pointer exchange
    part_ptr_t word_rd_ptr [num_ports];
    part_ptr_t attr_wr_ptr [num_ports];

    ingress_write_sched #(
        .num_ports (num_ports)
    ) write_sched (
        .ing_bus      (ing_bus),
        .rst_n        (rst_n),
        .in_word      (in_word),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .word_rd_ptr  (word_rd_ptr),
        .word_wr_en   (word_wr_en),
        .word_wr_addr (word_wr_addr),
        .word_wr_data (word_wr_data),
        .attr_wr_en   (attr_wr_en),
        .attr_wr_addr (attr_wr_addr),
        .attr_wr_data (attr_wr_data),
        .attr_wr_ptr  (attr_wr_ptr),
        .overflow     (overflow)
    );

    ingress_part_ram #(
        .depth     (num_ports * part_depth),
        .payload_t (word_data_t)
    ) word_ram (
        .ing_bus (ing_bus),
        .wr_en   (word_wr_en),
        .wr_addr (word_wr_addr),
        .wr_data (word_wr_data),
        .rd_addr (word_rd_addr),
        .rd_data (word_rd_data)
    );

    // A packet is at least one word, so one entry per word slot is enough
    ingress_part_ram #(
        .depth     (num_ports * part_depth),
        .payload_t (pkt_attr_t)
    ) attr_ram (
        .ing_bus (ing_bus),
        .wr_en   (attr_wr_en),
        .wr_addr (attr_wr_addr),
        .wr_data (attr_wr_data),
        .rd_addr (attr_rd_addr),
        .rd_data (attr_rd_data)
    );

    ingress_read_sched #(
        .num_ports (num_ports)
    ) read_sched (
        .ing_bus      (ing_bus),
        .rst_n        (rst_n),
        .attr_wr_ptr  (attr_wr_ptr),
        .attr_rd_addr (attr_rd_addr),
        .attr_rd_data (attr_rd_data),
        .word_rd_addr (word_rd_addr),
        .word_rd_data (word_rd_data),
        .word_rd_ptr  (word_rd_ptr),
        .out_valid    (out_valid),
        .out_word     (out_word)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ingress buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_router_ingress -f project.f

./obj_dir/Vtb_router_ingress > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* tb_router_ingress.sv */
/* Three-port directed test; payload bytes follow from port, packet and word numbers.
   The output bus has no ready, so the monitor takes a word on every valid cycle. */

`timescale 1ns/1ps

module tb_router_ingress;

    import router_ingress_pkg::*;

    localparam int n_ports = 3;

    logic               ing_bus;
    logic               rst_n;
    stream_word_t       in_word [n_ports];
    logic [n_ports-1:0] in_valid;
    logic [n_ports-1:0] in_ready;
    logic               out_valid;
    ing_out_t           out_word;
    logic [n_ports-1:0] overflow;

    // Scoreboard keeps one queue of packets per port
    int exp_len [n_ports][$];
    int exp_id [n_ports][$];
    int pkt_seq [n_ports];
    int ovf_high [n_ports];
    int pkts_exp;
    int pkts_rx;
    int words_sent;
    int n_checks;
    int errors;
    int cycles;
    int seed;

    // Packet currently on the output
    logic mon_active;
    int   mon_port;
    int   mon_len;
    int   mon_id;
    int   mon_idx;

    router_ingress_top #(
        .num_ports (n_ports)
    ) i_dut (
        .ing_bus   (ing_bus),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .overflow  (overflow)
    );

    initial begin
        ing_bus = 1'b0;
        forever #4 ing_bus = ~ing_bus;
    end

    ////////////////////
    // Reference model

    function automatic logic [7:0] word_keep(input int idx, input int nbytes);
        int nw;
        int rem;
        nw  = (nbytes + 7) / 8;
        rem = nbytes % 8;
        if (idx < nw - 1 || rem == 0) begin
            return 8'hff;
        end
        return 8'((1 << rem) - 1);
    endfunction

    function automatic logic [63:0] word_data(input int port, input int id, input int idx,
                                              input int nbytes);
        logic [63:0] d;
        logic [7:0]  k;
        d = {8'(8'ha0 + port), 8'(id), 8'(idx), 8'hc3, 32'h9e37_79b9 * 32'(id + 1) ^ 32'(idx)};
        k = word_keep(idx, nbytes);
        // Bytes beyond the packet end are sent as zero
        for (int b = 0; b < 8; b++) begin
            if (!k[b]) begin
                d[b*8 +: 8] = 8'h00;
            end
        end
        return d;
    endfunction

    function automatic int queued_packets();
        int n;
        n = 0;
        for (int p = 0; p < n_ports; p++) begin
            n += exp_len[p].size();
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // Drivers

    task automatic send_packet(input int port, input int nbytes, input bit expect_drop);
        int nw;
        int id;
        nw = (nbytes + 7) / 8;
        id = pkt_seq[port];
        pkt_seq[port]++;
        words_sent += nw;
        if (!expect_drop) begin
            exp_len[port].push_back(nbytes);
            exp_id[port].push_back(id);
            pkts_exp++;
        end
        for (int w = 0; w < nw; w++) begin
            in_word[port].data = word_data(port, id, w, nbytes);
            in_word[port].keep = word_keep(w, nbytes);
            in_word[port].last = (w == nw - 1);
            in_valid[port]     = 1'b1;
            // Ready seen at a falling edge holds through the next rising edge
            while (!in_ready[port]) begin
                @(negedge ing_bus);
            end
            @(negedge ing_bus);
        end
        in_valid[port] = 1'b0;
    endtask

    task automatic send_random(input int port, input int count);
        int nbytes;
        for (int i = 0; i < count; i++) begin
            nbytes = 1 + ($urandom % 200);
            // Third packet is a whole number of words
            if (i == 2) begin
                nbytes = 8 * (1 + ($urandom % 25));
            end
            send_packet(port, nbytes, 1'b0);
        end
    endtask

    task automatic wait_drain();
        while (queued_packets() != 0 || mon_active) begin
            @(negedge ing_bus);
        end
        repeat (4) @(negedge ing_bus);
        check_value("packets received", 64'(pkts_rx), 64'(pkts_exp));
    endtask

    ////////////////////
    // Monitor

    task automatic take_out_word();
        int p;
        int nw;
        bit known;
        if (!mon_active) begin
            p     = int'(out_word.meta.port_id);
            known = (p < n_ports);
            if (known) begin
                known = (exp_len[p].size() > 0);
            end
            assert (known) else begin
                errors++;
                $display("Packet from port %0d appeared at %0t but none was pending", p, $time);
            end
            if (known) begin
                mon_port   = p;
                mon_len    = exp_len[p].pop_front();
                mon_id     = exp_id[p].pop_front();
                mon_idx    = 0;
                mon_active = 1'b1;
            end
        end
        if (mon_active) begin
            nw = (mon_len + 7) / 8;
            check_value("out_word.meta.port_id", 64'(out_word.meta.port_id), 64'(mon_port));
            check_value("out_word.meta.byte_len", 64'(out_word.meta.byte_len), 64'(mon_len));
            check_value("out_word.data", out_word.data,
                        word_data(mon_port, mon_id, mon_idx, mon_len));
            check_value("out_word.keep", 64'(out_word.keep), 64'(word_keep(mon_idx, mon_len)));
            check_value("out_word.last", 64'(out_word.last), 64'(mon_idx == nw - 1));
            mon_idx++;
            if (out_word.last || mon_idx >= nw) begin
                mon_active = 1'b0;
                pkts_rx++;
            end
        end
    endtask

    always @(negedge ing_bus) begin
        if (rst_n) begin
            for (int p = 0; p < n_ports; p++) begin
                ovf_high[p] += int'(overflow[p]);
            end
            if (out_valid) begin
                take_out_word();
            end else begin
                assert (!mon_active) else begin
                    errors++;
                    $display("Packet from port %0d broke off after %0d words", mon_port, mon_idx);
                end
                mon_active = 1'b0;
            end
        end
    end

    ////////////////////
    // Tests

    task automatic check_reset_state();
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("overflow", 64'(overflow), 64'd0);
        for (int c = 0; c < 2 * n_ports; c++) begin
            check_value("in_ready", 64'(in_ready), 64'd1 << (c % n_ports));
            @(negedge ing_bus);
        end
    endtask

    task automatic single_packet_delivery();
        send_packet(1, 21, 1'b0);
        wait_drain();
    endtask

    task automatic concurrent_ports();
        fork
            send_random(0, 5);
            send_random(1, 5);
            send_random(2, 5);
        join
        wait_drain();
    endtask

    task automatic overflow_drop();
        wait_drain();
        fork
            begin
                send_packet(2, 70 * 8, 1'b1);
                send_packet(2, 16, 1'b0);
            end
            send_random(0, 3);
            send_random(1, 3);
        join
        wait_drain();
        check_value("overflow[2] cycles", 64'(ovf_high[2]), 64'd1);
    endtask

    task automatic partition_refill();
        // 16 packets of 5 to 8 words overrun a 64-word partition
        for (int i = 0; i < 16; i++) begin
            send_packet(0, 33 + ($urandom % 32), 1'b0);
        end
        wait_drain();
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, packets: %0d of %0d",
                 n_checks, errors, pkts_rx, pkts_exp);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        seed       = $urandom(32'h6ee9);
        rst_n      = 1'b0;
        in_valid   = '0;
        in_word    = '{default: '0};
        pkt_seq    = '{default: 0};
        ovf_high   = '{default: 0};
        mon_active = 1'b0;
        // Hold reset over three rising edges
        repeat (3) @(posedge ing_bus);
        @(negedge ing_bus);
        rst_n = 1'b1;
        check_reset_state();
        single_packet_delivery();
        concurrent_ports();
        overflow_drop();
        partition_refill();
        check_value("overflow[0] cycles", 64'(ovf_high[0]), 64'd0);
        check_value("overflow[1] cycles", 64'(ovf_high[1]), 64'd0);
        finish_run();
    end

    // Watchdog limit grows with every word queued for sending
    initial begin
        cycles = 0;
        do begin
            @(posedge ing_bus);
            cycles++;
        end while (cycles <= 200 * words_sent + 2000);
        errors++;
        $display("Timeout after %0d cycles, %0d packets never came out", cycles, queued_packets());
        finish_run();
    end

endmodule
